// File: source/faas_settings.svh
`ifndef FAAS_SETTINGS_SVH
`define FAAS_SETTINGS_SVH

// ===========================================================================
// word and address widths
// ===========================================================================
`define FAAS_DATA_WIDTH 32      // bank and register word
`define FAAS_ADDR_WIDTH 16      // host word address

// ===========================================================================
// bank geometry
// ===========================================================================
`define FAAS_DDR_AW     10
`define FAAS_DDR_DEPTH  1024    // 2**FAAS_DDR_AW words

`define FAAS_REG_AW     3       // register index

`endif

// File: source/faas_bus_pkg.sv
`include "faas_settings.svh"

package faas_bus_pkg;

        typedef logic [`FAAS_DATA_WIDTH-1:0] ddr_word_t;
        typedef logic [`FAAS_DDR_AW-1:0]     ddr_addr_t;

        // host word address seen as a register index
        typedef struct packed {
                logic                                        region;   // 0 here
                logic [`FAAS_ADDR_WIDTH-`FAAS_REG_AW-2:0]    pad;
                logic [`FAAS_REG_AW-1:0]                     idx;
        } reg_view_t;

        // same word seen as a bank window address
        typedef struct packed {
                logic                                        region;   // 1 here
                logic [`FAAS_ADDR_WIDTH-`FAAS_DDR_AW-2:0]    pad;
                ddr_addr_t                                   addr;
        } mem_view_t;

        typedef union packed {
                reg_view_t reg_view;
                mem_view_t mem_view;
        } host_addr_u;

endpackage

// File: source/faas_reg_pkg.sv
package faas_reg_pkg;

        // ===================================================================
        // register map, one word per index
        // ===================================================================
        typedef enum logic [2:0] {
                REG_SRC    = 3'd0,      // first source word
                REG_DST    = 3'd1,      // first destination word
                REG_LEN    = 3'd2,      // words to move
                REG_CTRL   = 3'd3,
                REG_STATUS = 3'd4
        } reg_idx_e;

        localparam int CTRL_START = 0;  // ctrl bit, write 1 to launch

        // status word bits, busy at bit 0
        typedef struct packed {
                logic done;
                logic busy;
        } copy_status_t;

endpackage

// File: source/faas_interfaces.sv
`timescale 1ns/100ps

// wishbone classic path toward the bank
interface ddr_port_if;
        logic                   cyc;
        logic                   stb;
        logic                   we;
        faas_bus_pkg::ddr_addr_t adr;
        faas_bus_pkg::ddr_word_t dat_w;
        faas_bus_pkg::ddr_word_t dat_r;
        logic                   ack;    // one cycle per request

        modport initiator (output cyc, stb, we, adr, dat_w, input dat_r, ack);
        modport target    (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

// single cycle register strobe, read data is combinational
interface reg_bus_if;
        logic                    stb;
        logic                    we;
        faas_reg_pkg::reg_idx_e  idx;
        faas_bus_pkg::ddr_word_t wdata;
        faas_bus_pkg::ddr_word_t rdata;

        modport master (output stb, we, idx, wdata, input rdata);
        modport slave  (input stb, we, idx, wdata, output rdata);
endinterface

// File: source/alite_host_port.sv
`timescale 1ns/100ps

module alite_host_port (
        input  logic                       pcie_axi_aclk,
        input  logic                       rst,
        input  logic                       awvalid,
        output logic                       awready,
        input  faas_bus_pkg::host_addr_u   awaddr,
        input  logic                       wvalid,
        output logic                       wready,
        input  faas_bus_pkg::ddr_word_t    wdata,
        output logic                       bvalid,
        input  logic                       bready,
        input  logic                       arvalid,
        output logic                       arready,
        input  faas_bus_pkg::host_addr_u   araddr,
        output logic                       rvalid,
        input  logic                       rready,
        output faas_bus_pkg::ddr_word_t    rdata,
        reg_bus_if.master                  regs,
        ddr_port_if.initiator              mem
);

typedef enum logic [1:0] {ST_IDLE, ST_REG, ST_MEM, ST_RESP} state_e;

state_e                    state;
faas_bus_pkg::host_addr_u  acc_addr;   // address of the access being accepted
faas_bus_pkg::host_addr_u  addr_q;
faas_bus_pkg::ddr_word_t   wdata_q;
faas_bus_pkg::ddr_word_t   rdata_q;
logic                      wr_q;
logic                      accept;

// ===========================================================================
// accept, reads win a tie
// ===========================================================================
assign arready  = (state == ST_IDLE) && arvalid;
assign awready  = (state == ST_IDLE) && awvalid && wvalid && !arvalid;
assign wready   = awready;
assign accept   = arready || awready;
assign acc_addr = arvalid ? araddr : awaddr;

assign bvalid = (state == ST_RESP) && wr_q;
assign rvalid = (state == ST_RESP) && !wr_q;
assign rdata  = rdata_q;       // held through ST_RESP

assign regs.stb   = (state == ST_REG);
assign regs.we    = wr_q;
assign regs.idx   = faas_reg_pkg::reg_idx_e'(addr_q.reg_view.idx);
assign regs.wdata = wdata_q;

assign mem.cyc   = (state == ST_MEM);
assign mem.stb   = (state == ST_MEM);
assign mem.we    = wr_q;
assign mem.adr   = addr_q.mem_view.addr;
assign mem.dat_w = wdata_q;

always_ff @(posedge pcie_axi_aclk)
begin
        if (rst)
        begin
                state <= ST_IDLE;
                wr_q  <= 1'b0;
        end
        else
        begin
                case (state)
                ST_IDLE:
                begin
                        if (accept)
                        begin
                                wr_q  <= !arvalid;
                                state <= acc_addr.mem_view.region ? ST_MEM : ST_REG;
                        end
                end
                ST_REG:  state <= ST_RESP;          // strobe lasts one cycle
                ST_MEM:
                begin
                        if (mem.ack)
                                state <= ST_RESP;
                end
                default:
                begin
                        if (wr_q ? bready : rready)
                                state <= ST_IDLE;
                end
                endcase
        end
end

// payload capture
always_ff @(posedge pcie_axi_aclk)
begin
        if (accept)
        begin
                addr_q  <= acc_addr;
                wdata_q <= wdata;
        end
        if (state == ST_REG)
                rdata_q <= regs.rdata;
        else if (state == ST_MEM && mem.ack)
                rdata_q <= mem.dat_r;
end

endmodule

// File: source/copy_engine.sv
`timescale 1ns/100ps

module copy_engine (
        input  logic          pcie_axi_aclk,
        input  logic          rst,
        input  logic          usr_int_en,
        input  logic          usr_int_ack,
        output logic          usr_int_req,
        reg_bus_if.slave      regs,
        ddr_port_if.initiator mem
);

typedef enum logic [1:0] {ST_IDLE, ST_RD, ST_WR} state_e;

state_e                     state;
faas_bus_pkg::ddr_word_t    src_q;
faas_bus_pkg::ddr_word_t    dst_q;
faas_bus_pkg::ddr_word_t    len_q;
faas_bus_pkg::ddr_word_t    idx_q;     // word offset within the block
faas_bus_pkg::ddr_word_t    data_q;    // the one word in flight
faas_reg_pkg::copy_status_t status;
logic                       done_q;
logic                       done_d;
logic                       start;
logic                       last_word;

assign start = regs.stb && regs.we && (regs.idx == faas_reg_pkg::REG_CTRL)
               && regs.wdata[faas_reg_pkg::CTRL_START];
assign last_word = (idx_q + 32'd1) == len_q;

assign status.busy = (state != ST_IDLE);
assign status.done = done_q;

// ===========================================================================
// register file
// ===========================================================================
always_ff @(posedge pcie_axi_aclk)
begin
        if (regs.stb && regs.we)
        begin
                case (regs.idx)
                faas_reg_pkg::REG_SRC: src_q <= regs.wdata;
                faas_reg_pkg::REG_DST: dst_q <= regs.wdata;
                faas_reg_pkg::REG_LEN: len_q <= regs.wdata;
                default: ;
                endcase
        end
end

always_comb
begin
        regs.rdata = '0;
        case (regs.idx)
        faas_reg_pkg::REG_SRC:    regs.rdata = src_q;
        faas_reg_pkg::REG_DST:    regs.rdata = dst_q;
        faas_reg_pkg::REG_LEN:    regs.rdata = len_q;
        faas_reg_pkg::REG_STATUS: regs.rdata[$bits(status)-1:0] = status;
        default: ;                              // ctrl and spare read 0
        endcase
end

// ===========================================================================
// copy FSM, read src+i then write dst+i
// ===========================================================================
assign mem.cyc   = (state != ST_IDLE);
assign mem.stb   = (state != ST_IDLE);
assign mem.we    = (state == ST_WR);
assign mem.adr   = (state == ST_WR) ? faas_bus_pkg::ddr_addr_t'(dst_q + idx_q)
                                    : faas_bus_pkg::ddr_addr_t'(src_q + idx_q);
assign mem.dat_w = data_q;

always_ff @(posedge pcie_axi_aclk)
begin
        if (rst)
        begin
                state  <= ST_IDLE;
                done_q <= 1'b0;
        end
        else
        begin
                case (state)
                ST_IDLE:
                begin
                        if (start)
                        begin
                                idx_q  <= '0;
                                done_q <= (len_q == '0);   // empty copy ends at once
                                state  <= (len_q == '0) ? ST_IDLE : ST_RD;
                        end
                end
                ST_RD:
                begin
                        if (mem.ack)
                        begin
                                data_q <= mem.dat_r;
                                state  <= ST_WR;
                        end
                end
                default:
                begin
                        if (mem.ack)
                        begin
                                idx_q <= idx_q + 32'd1;
                                if (last_word)
                                begin
                                        done_q <= 1'b1;
                                        state  <= ST_IDLE;
                                end
                                else
                                        state <= ST_RD;
                        end
                end
                endcase
        end
end

// level request, raised on done and held until acknowledged
always_ff @(posedge pcie_axi_aclk)
begin
        if (rst)
        begin
                done_d      <= 1'b0;
                usr_int_req <= 1'b0;
        end
        else
        begin
                done_d <= done_q;
                if (usr_int_en && done_q && !done_d)
                        usr_int_req <= 1'b1;
                else if (usr_int_ack)
                        usr_int_req <= 1'b0;
        end
end

endmodule

// File: source/ddr_arbiter.sv
`timescale 1ns/100ps

module ddr_arbiter (
        input  logic          pcie_axi_aclk,
        input  logic          rst,
        ddr_port_if.target    host_side,
        ddr_port_if.target    copy_side,
        ddr_port_if.initiator bank_side
);

logic sel_copy;    // 1 routes the copy engine to the bank
logic lock_q;      // a cycle is under way
logic owner_q;
logic last_q;      // 1 when the copy engine had the last grant

// round robin between new requests, locked owner otherwise
assign sel_copy = lock_q ? owner_q
                         : (copy_side.cyc && (!host_side.cyc || !last_q));

assign bank_side.cyc   = sel_copy ? copy_side.cyc   : host_side.cyc;
assign bank_side.stb   = sel_copy ? copy_side.stb   : host_side.stb;
assign bank_side.we    = sel_copy ? copy_side.we    : host_side.we;
assign bank_side.adr   = sel_copy ? copy_side.adr   : host_side.adr;
assign bank_side.dat_w = sel_copy ? copy_side.dat_w : host_side.dat_w;

assign host_side.ack   = bank_side.ack && !sel_copy;
assign copy_side.ack   = bank_side.ack && sel_copy;
assign host_side.dat_r = sel_copy ? '0 : bank_side.dat_r;
assign copy_side.dat_r = sel_copy ? bank_side.dat_r : '0;

always_ff @(posedge pcie_axi_aclk)
begin
        if (rst)
        begin
                lock_q  <= 1'b0;
                owner_q <= 1'b0;
                last_q  <= 1'b0;
        end
        else if (bank_side.ack)
        begin
                lock_q <= 1'b0;        // grant free again after ack
                last_q <= sel_copy;
        end
        else if (bank_side.cyc)
        begin
                lock_q  <= 1'b1;
                owner_q <= sel_copy;
        end
end

endmodule

// File: source/ddr_bank.sv
`timescale 1ns/100ps

`include "faas_settings.svh"

module ddr_bank (
        input  logic       pcie_axi_aclk,
        input  logic       rst,
        ddr_port_if.target port
);

faas_bus_pkg::ddr_word_t mem [`FAAS_DDR_DEPTH];
faas_bus_pkg::ddr_word_t dat_r_q;
logic                    ack_q;
logic                    req;

// a held stb counts once, the ack cycle is not a new request
assign req = port.cyc && port.stb && !ack_q;

assign port.ack   = ack_q;
assign port.dat_r = dat_r_q;

always_ff @(posedge pcie_axi_aclk)
begin
        if (rst)
                ack_q <= 1'b0;
        else
                ack_q <= req;
end

always_ff @(posedge pcie_axi_aclk)
begin
        if (req && port.we)
                mem[port.adr] <= port.dat_w;
        if (req)
                dat_r_q <= mem[port.adr];   // old data on a write, unused there
end

endmodule

// File: source/faas_usr_top.sv
`timescale 1ns/100ps

module faas_usr_top (
        input  logic                     pcie_axi_aclk,
        input  logic                     rst,
        // write channels
        input  logic                     awvalid,
        output logic                     awready,
        input  faas_bus_pkg::host_addr_u awaddr,
        input  logic                     wvalid,
        output logic                     wready,
        input  faas_bus_pkg::ddr_word_t  wdata,
        output logic                     bvalid,
        input  logic                     bready,
        // read channels
        input  logic                     arvalid,
        output logic                     arready,
        input  faas_bus_pkg::host_addr_u araddr,
        output logic                     rvalid,
        input  logic                     rready,
        output faas_bus_pkg::ddr_word_t  rdata,
        // interrupt
        input  logic                     usr_int_en,
        output logic                     usr_int_req,
        input  logic                     usr_int_ack
);

// ===========================================================================
// internal buses
// ===========================================================================
reg_bus_if  reg_bus ();
ddr_port_if host_mem ();
ddr_port_if copy_mem ();
ddr_port_if bank_mem ();

alite_host_port u_host_port (
        .pcie_axi_aclk (pcie_axi_aclk),
        .rst           (rst),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .bvalid        (bvalid),
        .bready        (bready),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .regs          (reg_bus.master),
        .mem           (host_mem.initiator)
);

copy_engine u_copy_engine (
        .pcie_axi_aclk (pcie_axi_aclk),
        .rst           (rst),
        .usr_int_en    (usr_int_en),
        .usr_int_ack   (usr_int_ack),
        .usr_int_req   (usr_int_req),
        .regs          (reg_bus.slave),
        .mem           (copy_mem.initiator)
);

ddr_arbiter u_ddr_arbiter (
        .pcie_axi_aclk (pcie_axi_aclk),
        .rst           (rst),
        .host_side     (host_mem.target),
        .copy_side     (copy_mem.target),
        .bank_side     (bank_mem.initiator)
);

ddr_bank u_ddr_bank (
        .pcie_axi_aclk (pcie_axi_aclk),
        .rst           (rst),
        .port          (bank_mem.target)
);

endmodule

// File: verification/faas_usr_asserts.sv
`timescale 1ns/100ps

module faas_usr_asserts (
        input  logic                    pcie_axi_aclk,
        input  logic                    rst,
        input  logic                    bvalid,
        input  logic                    bready,
        input  logic                    rvalid,
        input  logic                    rready,
        input  faas_bus_pkg::ddr_word_t rdata,
        input  logic                    usr_int_req,
        input  logic                    usr_int_ack
);

// write response waits for the host
a_bvalid_hold: assert property (@(posedge pcie_axi_aclk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid fell before bready");

// read response and its data stay put
a_rvalid_hold: assert property (@(posedge pcie_axi_aclk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

a_int_hold: assert property (@(posedge pcie_axi_aclk) disable iff (rst)
        usr_int_req && !usr_int_ack |=> usr_int_req)
        else $error("usr_int_req fell before usr_int_ack");

endmodule

bind faas_usr_top faas_usr_asserts u_asserts (
        .pcie_axi_aclk (pcie_axi_aclk),
        .rst           (rst),
        .bvalid        (bvalid),
        .bready        (bready),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .usr_int_req   (usr_int_req),
        .usr_int_ack   (usr_int_ack)
);

// File: verification/tb_faas_usr_top.sv
`timescale 1ns/100ps

`include "faas_settings.svh"

module tb_faas_usr_top;

localparam int MAX_CYCLES = 20000;     // about ten times the longest expected run

logic        clk;
logic        rst;
logic        awvalid;
logic        awready;
logic [15:0] awaddr;
logic        wvalid;
logic        wready;
logic [31:0] wdata;
logic        bvalid;
logic        bready;
logic        arvalid;
logic        arready;
logic [15:0] araddr;
logic        rvalid;
logic        rready;
logic [31:0] rdata;
logic        usr_int_en;
logic        usr_int_req;
logic        usr_int_ack;

logic [31:0] lfsr_state = 32'hb966;
logic [31:0] model_mem [`FAAS_DDR_DEPTH];
logic [9:0]  written_q [$];            // bank addresses touched in test 1
logic [31:0] got_q [$];
logic [31:0] exp_q [$];
logic [15:0] adr_q [$];
logic [31:0] cmp_got;
logic [31:0] cmp_exp;
logic [15:0] cmp_adr;
int          errors;
int          checks;
int          tests;
int          base_errors;
int          cycle_count;
logic        int_seen;

faas_usr_top DUT (
        .pcie_axi_aclk (clk),
        .rst           (rst),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .bvalid        (bvalid),
        .bready        (bready),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .usr_int_en    (usr_int_en),
        .usr_int_req   (usr_int_req),
        .usr_int_ack   (usr_int_ack)
);

initial
begin
        clk = 1'b0;
        forever #10 clk = ~clk;
end

// ===========================================================================
// random source and reference model
// ===========================================================================
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
endfunction

task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
                lfsr_state = lfsr_next(lfsr_state);
                v = {v[30:0], lfsr_state[0]};   // one step per bit
        end
endtask

// word by word in ascending order as the engine moves them
function automatic void model_copy(input logic [9:0] src, input logic [9:0] dst, input int len);
        logic [9:0] s;
        logic [9:0] d;
        int         i;
        s = src;
        d = dst;
        for (i = 0; i < len; i++)
        begin
                model_mem[d] = model_mem[s];
                s++;
                d++;
        end
endfunction

function automatic logic [15:0] reg_addr(input logic [2:0] idx);
        return {1'b0, 12'd0, idx};     // region 0
endfunction

function automatic logic [15:0] mem_addr(input logic [9:0] a);
        return {1'b1, 5'd0, a};        // region 1 selects the bank window
endfunction

// ===========================================================================
// host access tasks start and end 2 ns after a rising edge
// ===========================================================================
task automatic host_write(input logic [15:0] addr, input logic [31:0] data, input int hold);
        int n;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        do @(negedge clk); while (!awready);
        if (!wready)
        begin
                errors++;
                $display("wready stayed low while awready accepted the write, at %0t", $time);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(negedge clk); while (!bvalid);
        for (n = 0; n < hold; n++)
        begin
                @(negedge clk);
                if (!bvalid)
                begin
                        errors++;
                        $display("bvalid dropped while bready was low, at %0t", $time);
                end
        end
        @(posedge clk);
        #2;
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
endtask

task automatic host_read(input logic [15:0] addr, input int hold, output logic [31:0] data);
        int n;
        arvalid = 1'b1;
        araddr  = addr;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        for (n = 0; n < hold; n++)
        begin
                @(negedge clk);
                if (!rvalid)
                begin
                        errors++;
                        $display("rvalid dropped while rready was low, at %0t", $time);
                end
                if (rdata !== data)
                begin
                        errors++;
                        $display("mismatch at %0t: rdata changed from %h to %h under back-pressure",
                                 $time, data, rdata);
                end
        end
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(posedge clk);
        #2;
        rready = 1'b0;
endtask

// read and hand the result to the comparing process
task automatic check_read(input logic [15:0] addr, input logic [31:0] exp, input int hold);
        logic [31:0] got;
        host_read(addr, hold, got);
        got_q.push_back(got);
        exp_q.push_back(exp);
        adr_q.push_back(addr);
endtask

task automatic fill_block(input logic [9:0] src, input int len);
        logic [31:0] d;
        logic [9:0]  a;
        int          i;
        a = src;
        for (i = 0; i < len; i++)
        begin
                random_bits(32, d);
                host_write(mem_addr(a), d, 0);
                model_mem[a] = d;
                a++;
        end
endtask

task automatic start_copy(input logic [9:0] src, input logic [9:0] dst, input int len);
        host_write(reg_addr(faas_reg_pkg::REG_SRC), 32'(src), 0);
        host_write(reg_addr(faas_reg_pkg::REG_DST), 32'(dst), 0);
        host_write(reg_addr(faas_reg_pkg::REG_LEN), 32'(len), 0);
        host_write(reg_addr(faas_reg_pkg::REG_CTRL), 32'h1, 0);
        model_copy(src, dst, len);
endtask

// poll status until done and expect busy clear
task automatic wait_copy_done();
        logic [31:0] st;
        st = '0;
        while (!st[1])
                host_read(reg_addr(faas_reg_pkg::REG_STATUS), 0, st);
        got_q.push_back(st);
        exp_q.push_back(32'h2);
        adr_q.push_back(reg_addr(faas_reg_pkg::REG_STATUS));
endtask

task automatic check_block(input logic [9:0] dst, input int len);
        logic [9:0] a;
        int         i;
        a = dst;
        for (i = 0; i < len; i++)
        begin
                check_read(mem_addr(a), model_mem[a], 0);
                a++;
        end
endtask

task automatic finish_test(input string name);
        while (got_q.size() != 0)
                @(negedge clk);
        tests++;
        $display("%-14s %0d errors", name, errors - base_errors);
        base_errors = errors;
        @(posedge clk);
        #2;
endtask

// ===========================================================================
// comparing process and monitors
// ===========================================================================
always @(negedge clk)
begin
        while (got_q.size() != 0)
        begin
                cmp_got = got_q.pop_front();
                cmp_exp = exp_q.pop_front();
                cmp_adr = adr_q.pop_front();
                checks++;
                if (cmp_got !== cmp_exp)
                begin
                        errors++;
                        $display("mismatch at %0t: read of %h returned %h, expected %h",
                                 $time, cmp_adr, cmp_got, cmp_exp);
                end
        end
end

always @(posedge clk)
begin
        if (usr_int_req)
                int_seen = 1'b1;
end

always @(posedge clk)
begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
                $display("timeout after %0d cycles, an access or copy never finished", cycle_count);
                $display("TEST FAILED");
                $finish;
        end
end

// ===========================================================================
// stimulus
// ===========================================================================
initial
begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] h;
        logic [9:0]  a;
        int          i;
        int          n;

        rst         = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        usr_int_en  = 1'b0;
        usr_int_ack = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        base_errors = 0;
        cycle_count = 0;
        int_seen    = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // window write and read-back
        for (i = 0; i < 32; i++)
        begin
                random_bits(10, r);
                random_bits(32, d);
                a = r[9:0];
                host_write(mem_addr(a), d, 0);
                model_mem[a] = d;
                written_q.push_back(a);
        end
        foreach (written_q[k])
                check_read(mem_addr(written_q[k]), model_mem[written_q[k]], 0);
        finish_test("window_rw");

        // register read-back where spare indices read 0
        random_bits(32, r);
        host_write(reg_addr(faas_reg_pkg::REG_SRC), r, 0);
        check_read(reg_addr(faas_reg_pkg::REG_SRC), r, 0);
        random_bits(32, r);
        host_write(reg_addr(faas_reg_pkg::REG_DST), r, 0);
        check_read(reg_addr(faas_reg_pkg::REG_DST), r, 0);
        random_bits(32, r);
        host_write(reg_addr(faas_reg_pkg::REG_LEN), r, 0);
        check_read(reg_addr(faas_reg_pkg::REG_LEN), r, 0);
        check_read(reg_addr(3'd5), 32'h0, 0);
        check_read(reg_addr(3'd7), 32'h0, 0);
        finish_test("registers");

        // block copy with the interrupt disabled
        fill_block(10'd64, 16);
        start_copy(10'd64, 10'd256, 16);
        wait_copy_done();
        check_block(10'd256, 16);
        finish_test("copy");

        // ===================================================================
        // interrupt request and acknowledge
        // ===================================================================
        usr_int_en = 1'b1;
        fill_block(10'd400, 8);
        start_copy(10'd400, 10'd480, 8);
        wait_copy_done();
        n = 0;
        while (!usr_int_req && n < 10)
        begin
                @(negedge clk);
                n++;
        end
        if (!usr_int_req)
        begin
                errors++;
                $display("usr_int_req did not rise after the copy finished");
        end
        repeat (5)
        begin
                @(negedge clk);
                if (!usr_int_req)
                begin
                        errors++;
                        $display("usr_int_req fell before usr_int_ack, at %0t", $time);
                end
        end
        @(posedge clk);
        #2;
        usr_int_ack = 1'b1;
        @(posedge clk);
        #2;
        usr_int_ack = 1'b0;
        @(negedge clk);
        if (usr_int_req)
        begin
                errors++;
                $display("usr_int_req still high after usr_int_ack, at %0t", $time);
        end
        @(posedge clk);
        #2;
        usr_int_en = 1'b0;                     // next copy must stay silent
        int_seen   = 1'b0;
        fill_block(10'd520, 5);
        start_copy(10'd520, 10'd560, 5);
        wait_copy_done();
        repeat (4) @(posedge clk);
        #2;
        if (int_seen)
        begin
                errors++;
                $display("usr_int_req raised while usr_int_en was low");
        end
        check_block(10'd560, 5);
        finish_test("interrupt");

        // window reads while the engine owns part of the bank
        fill_block(10'd700, 40);
        start_copy(10'd700, 10'd800, 40);
        n = 0;
        foreach (written_q[k])
        begin
                a = written_q[k];
                if (n < 8 && !(a >= 10'd700 && a < 10'd740) && !(a >= 10'd800 && a < 10'd840))
                begin
                        check_read(mem_addr(a), model_mem[a], 0);
                        n++;
                end
        end
        host_read(reg_addr(faas_reg_pkg::REG_STATUS), 0, r);
        if (!r[0])
        begin
                errors++;
                $display("copy finished before the shared reads were done");
        end
        wait_copy_done();
        check_block(10'd800, 40);
        finish_test("shared");

        // responses held back by the host
        for (i = 0; i < 4; i++)
        begin
                random_bits(10, r);
                random_bits(32, d);
                random_bits(3, h);
                a = r[9:0];
                host_write(mem_addr(a), d, int'(h) + 1);
                model_mem[a] = d;
                random_bits(3, h);
                check_read(mem_addr(a), model_mem[a], int'(h) + 1);
        end
        check_read(mem_addr(a), model_mem[a], 0);
        finish_test("backpressure");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
                $display("TEST OK");
        else
                $display("TEST FAILED");
        $finish;
end

endmodule

// File: verilog.f
+incdir+source
source/faas_bus_pkg.sv
source/faas_reg_pkg.sv
source/faas_interfaces.sv
source/alite_host_port.sv
source/copy_engine.sv
source/ddr_arbiter.sv
source/ddr_bank.sv
source/faas_usr_top.sv
verification/faas_usr_asserts.sv
verification/tb_faas_usr_top.sv

// File: run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_faas_usr_top -f verilog.f

./obj_dir/Vtb_faas_usr_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
        exit 1
fi
if ! grep -q "TEST OK" sim.log; then
        exit 1
fi
